/* files.f */
+incdir+test
verilog/mc_pkg.sv
verilog/mc_fifo.sv
verilog/mc_endpoint.sv
verilog/mc_dmem.sv
verilog/mc_tile_core.sv
verilog/mc_tile_top.sv
test/tb_mc_tile.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_mc_tile
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_mc_checks.svh */
// ****************************************
// typed compare tasks and error counters
// for the tile socket testbench
// ****************************************
`ifndef TB_MC_CHECKS_SVH
`define TB_MC_CHECKS_SVH

int mismatch_count = 0;
int failure_count  = 0;

task automatic check_rsp(input mc_pkg::mc_rsp_pkt_s exp, input mc_pkg::mc_rsp_pkt_s got,
                         input string what);
   if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected type %0d reg %0d data %08h dst %0d,%0d %s",
               $time, what, exp.rsp_type, exp.reg_id, exp.data, exp.dst_x, exp.dst_y,
               $sformatf("got type %0d reg %0d data %08h dst %0d,%0d",
                         got.rsp_type, got.reg_id, got.data, got.dst_x, got.dst_y));
   end
endtask

task automatic check_req(input mc_pkg::mc_req_pkt_s exp, input mc_pkg::mc_req_pkt_s got,
                         input string what);
   if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, got);
   end
endtask

task automatic check_credits(input credits_t exp, input credits_t got, input string what);
   if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, what, exp, got);
   end
endtask

task automatic check_bit(input logic exp, input logic got, input string what);
   if (got !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %b got %b", $time, what, exp, got);
   end
endtask

// timeouts and lost handshakes
task automatic report_failure(input string what);
   failure_count++;
   $display("ERROR at %0t: %s", $time, what);
endtask

`endif

/* test/tb_mc_tile.sv */
// ****************************************
// testbench for the tile socket with
// clock, reset, LFSR, request table
// and host path checks
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mc_tile;

   localparam int dmem_words      = 256;
   localparam int max_credits     = 4;
   localparam int credit_width    = $clog2(max_credits + 1);
   localparam int wait_limit      = 200;
   localparam int init_wait_limit = 2 * dmem_words + 50;
   localparam int n_steps         = 13;

   typedef logic [credit_width-1:0] credits_t;

   // one row of the request table
   typedef struct packed {
      mc_pkg::mc_op_e                       op;
      logic [mc_pkg::mc_addr_width-1:0]     addr;
      logic [mc_pkg::mc_mask_width-1:0]     mask;
      logic [mc_pkg::mc_reg_id_width-1:0]   reg_id;
      logic [mc_pkg::mc_x_width-1:0]        src_x;
      logic [mc_pkg::mc_y_width-1:0]        src_y;
   } step_s;

   logic                          clk_i;
   logic                          rst_n_i;
   mc_pkg::mc_link_in_s           link_in;
   mc_pkg::mc_link_out_s          link_out;
   logic [mc_pkg::mc_x_width-1:0] my_x;
   logic [mc_pkg::mc_y_width-1:0] my_y;
   logic                          host_req_v;
   mc_pkg::mc_req_pkt_s           host_req;
   logic                          host_req_ready;
   logic                          host_rsp_v;
   mc_pkg::mc_rsp_pkt_s           host_rsp;
   credits_t                      out_credits;

   step_s                         steps    [n_steps];
   mc_pkg::mc_req_pkt_s           requests [n_steps];
   mc_pkg::mc_rsp_pkt_s           expected [n_steps];
   logic [31:0]                   ref_mem  [dmem_words];
   logic [15:0]                   lfsr_r;
   logic                          stalled_r;

   always #10 clk_i = ~clk_i;

   mc_tile_top #(
      .dmem_words_p     (dmem_words),
      .max_out_credits_p(max_credits),
      .req_fifo_els_p   (2)
   ) dut (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .link_i          (link_in),
      .link_o          (link_out),
      .my_x_i          (my_x),
      .my_y_i          (my_y),
      .host_req_v_i    (host_req_v),
      .host_req_i      (host_req),
      .host_req_ready_o(host_req_ready),
      .host_rsp_v_o    (host_rsp_v),
      .host_rsp_o      (host_rsp),
      .out_credits_o   (out_credits)
   );

   `include "tb_mc_checks.svh"

   // 16-bit Fibonacci LFSR with taps 16 14 13 11
   function automatic logic next_rand_bit();
      logic fb;
      fb     = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];
      lfsr_r = {lfsr_r[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      for (int i = 0; i < 32; i++) begin
         w[i] = next_rand_bit();
      end
      return w;
   endfunction

   // build packets and expected responses while the reference memory follows table order
   task automatic build_table();
      mc_pkg::mc_req_pkt_s req;
      mc_pkg::mc_rsp_pkt_s rsp;
      int                  idx;
      for (int i = 0; i < n_steps; i++) begin
         idx       = int'(steps[i].addr) % dmem_words;
         req       = '0;
         req.op    = steps[i].op;
         req.mask  = steps[i].mask;
         req.addr  = steps[i].addr;
         req.src_x = steps[i].src_x;
         req.src_y = steps[i].src_y;
         req.dst_x = my_x;
         req.dst_y = my_y;
         rsp       = '0;
         rsp.dst_x = steps[i].src_x;
         rsp.dst_y = steps[i].src_y;
         if (steps[i].op == mc_pkg::op_store) begin
            req.payload.store_data = rand_word();
            for (int b = 0; b < mc_pkg::mc_mask_width; b++) begin
               if (steps[i].mask[b]) begin
                  ref_mem[idx][8*b +: 8] = req.payload.store_data[8*b +: 8];
               end
            end
            rsp.rsp_type = mc_pkg::rsp_store_ack;
         end else begin
            req.payload.load_info.reg_id = steps[i].reg_id;
            rsp.rsp_type = mc_pkg::rsp_load_data;
            rsp.reg_id   = steps[i].reg_id;
            rsp.data     = ref_mem[idx];
         end
         requests[i] = req;
         expected[i] = rsp;
      end
   endtask

   // hold a request on the link until the tile takes it
   task automatic send_req(input mc_pkg::mc_req_pkt_s pkt);
      int waited;
      waited         = 0;
      link_in.req_v <= 1'b1;
      link_in.req   <= pkt;
      do begin
         @(posedge clk_i);
         waited++;
      end while (!link_out.req_ready && waited < wait_limit);
      if (!link_out.req_ready) begin
         report_failure("link request not accepted by the tile before timeout");
      end
   endtask

   task automatic drive_table();
      for (int i = 0; i < n_steps; i++) begin
         send_req(requests[i]);
      end
      link_in.req_v <= 1'b0;
   endtask

   // wait for one response transfer while the LFSR toggles rsp_ready every cycle
   task automatic collect_rsp(input mc_pkg::mc_rsp_pkt_s exp);
      int   waited;
      logic done;
      waited = 0;
      done   = 1'b0;
      while (!done && waited < wait_limit) begin
         @(posedge clk_i);
         waited++;
         // a stalled response stays valid and unchanged
         if (stalled_r && !link_out.rsp_v) begin
            report_failure("response dropped while rsp_ready was low");
         end else if (stalled_r) begin
            check_rsp(exp, link_out.rsp, "held response");
         end
         stalled_r = link_out.rsp_v && !link_in.rsp_ready;
         if (link_out.rsp_v && link_in.rsp_ready) begin
            check_rsp(exp, link_out.rsp, "link response");
            done = 1'b1;
         end
         link_in.rsp_ready <= next_rand_bit();
      end
      if (!done) begin
         report_failure("no link response from the tile before timeout");
      end
   endtask

   task automatic collect_table();
      stalled_r = 1'b0;
      for (int i = 0; i < n_steps; i++) begin
         collect_rsp(expected[i]);
      end
      link_in.rsp_ready <= 1'b1;
   endtask

   // host request leaves on the link with this tile as source
   task automatic send_host(input mc_pkg::mc_req_pkt_s pkt);
      mc_pkg::mc_req_pkt_s exp;
      int                  waited;
      exp         = pkt;
      exp.src_x   = my_x;
      exp.src_y   = my_y;
      waited      = 0;
      host_req_v <= 1'b1;
      host_req   <= pkt;
      do begin
         @(posedge clk_i);
         waited++;
      end while (!host_req_ready && waited < wait_limit);
      if (host_req_ready) begin
         check_bit(1'b1, link_out.req_v, "outgoing req_v");
         check_req(exp, link_out.req, "outgoing request");
      end else begin
         report_failure("host request not accepted before timeout");
      end
      host_req_v <= 1'b0;
   endtask

   // a network response comes back on the host port and returns one credit
   task automatic inject_rsp(input mc_pkg::mc_rsp_pkt_s pkt, input credits_t exp_credits);
      int waited;
      waited         = 0;
      link_in.rsp_v <= 1'b1;
      link_in.rsp   <= pkt;
      @(posedge clk_i);
      check_bit(1'b1, link_out.rsp_ready, "link rsp_ready");
      link_in.rsp_v <= 1'b0;
      do begin
         @(posedge clk_i);
         waited++;
      end while (!host_rsp_v && waited < wait_limit);
      if (host_rsp_v) begin
         check_rsp(pkt, host_rsp, "host response");
         check_credits(exp_credits, out_credits, "credits after incoming response");
      end else begin
         report_failure("no host response pulse before timeout");
      end
   endtask

   initial begin
      int                  waited;
      mc_pkg::mc_req_pkt_s hreq;
      mc_pkg::mc_rsp_pkt_s irsp;
      clk_i      = 1'b0;
      rst_n_i    = 1'b0;
      link_in    = '0;
      host_req_v = 1'b0;
      host_req   = '0;
      my_x       = 4'd3;
      my_y       = 4'd5;
      lfsr_r     = 16'd83;
      stalled_r  = 1'b0;
      for (int a = 0; a < dmem_words; a++) begin
         ref_mem[a] = '0;
      end
      steps = '{
         // cleared memory right after reset
         '{mc_pkg::op_load,  16'h0000, 4'h0, 5'd1,  4'd1,  4'd0},
         '{mc_pkg::op_load,  16'h00ff, 4'h0, 5'd3,  4'd0,  4'd7},
         '{mc_pkg::op_store, 16'h0012, 4'hf, 5'd0,  4'd1,  4'd2},
         '{mc_pkg::op_load,  16'h0012, 4'h0, 5'd4,  4'd1,  4'd2},
         '{mc_pkg::op_load,  16'h0112, 4'h0, 5'd5,  4'd6,  4'd3},
         // partial writes merge with the old bytes
         '{mc_pkg::op_store, 16'h0012, 4'h5, 5'd0,  4'd2,  4'd2},
         '{mc_pkg::op_load,  16'h0012, 4'h0, 5'd6,  4'd2,  4'd2},
         '{mc_pkg::op_store, 16'h0040, 4'h8, 5'd0,  4'd4,  4'd4},
         '{mc_pkg::op_store, 16'h0140, 4'h3, 5'd0,  4'd5,  4'd1},
         '{mc_pkg::op_load,  16'h0040, 4'h0, 5'd31, 4'd4,  4'd4},
         '{mc_pkg::op_store, 16'h00a0, 4'h6, 5'd0,  4'd7,  4'd6},
         '{mc_pkg::op_load,  16'h00a0, 4'h0, 5'd9,  4'd15, 4'd15},
         '{mc_pkg::op_load,  16'h0037, 4'h0, 5'd2,  4'd3,  4'd5}
      };
      build_table();

      repeat (16) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      check_bit(1'b0, link_out.req_v, "req_v after reset");
      check_bit(1'b0, link_out.rsp_v, "rsp_v after reset");
      check_bit(1'b0, host_rsp_v, "host_rsp_v after reset");
      check_credits(credits_t'(max_credits), out_credits, "credits after reset");

      // the tile opens the link once memory clear is done
      waited = 0;
      while (!link_out.req_ready && waited < init_wait_limit) begin
         @(posedge clk_i);
         waited++;
      end
      if (!link_out.req_ready) begin
         report_failure("link req_ready never rose after reset");
      end

      fork
         drive_table();
         collect_table();
      join
      repeat (20) begin
         @(posedge clk_i);
         if (link_out.rsp_v) begin
            report_failure("extra link response after the table");
         end
      end

      // host path until the credits run out
      link_in.req_ready <= 1'b1;
      for (int k = 0; k < max_credits; k++) begin
         hreq                    = '0;
         hreq.op                 = mc_pkg::op_store;
         hreq.mask               = 4'hf;
         hreq.addr               = 16'(k);
         hreq.payload.store_data = rand_word();
         hreq.src_x              = 4'hf;
         hreq.src_y              = 4'hf;
         hreq.dst_x              = 4'd1;
         hreq.dst_y              = 4'd1;
         send_host(hreq);
         @(posedge clk_i);
         check_credits(credits_t'(max_credits - 1 - k), out_credits, "credits after send");
      end
      host_req_v <= 1'b1;
      repeat (8) begin
         @(posedge clk_i);
         check_bit(1'b0, host_req_ready, "host_req_ready with no credits");
         check_bit(1'b0, link_out.req_v, "req_v with no credits");
      end
      host_req_v <= 1'b0;

      for (int k = 0; k < max_credits; k++) begin
         irsp          = '0;
         irsp.rsp_type = k[0] ? mc_pkg::rsp_store_ack : mc_pkg::rsp_load_data;
         irsp.reg_id   = 5'(k + 7);
         irsp.data     = rand_word();
         irsp.dst_x    = my_x;
         irsp.dst_y    = my_y;
         inject_rsp(irsp, credits_t'(k + 1));
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/mc_tile_top.sv */
// ****************************************
// tile socket top: endpoint, core, dmem
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module mc_tile_top #(
   parameter int dmem_words_p      = 256,
   parameter int max_out_credits_p = 4,
   parameter int req_fifo_els_p    = 2,
   localparam int credit_width_lp  = $clog2(max_out_credits_p + 1),
   localparam int dmem_addr_width_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1
) (
   input  wire                           clk_i,
   input  wire                           rst_n_i,
   input  mc_pkg::mc_link_in_s           link_i,
   output mc_pkg::mc_link_out_s          link_o,
   input  wire  [mc_pkg::mc_x_width-1:0] my_x_i,
   input  wire  [mc_pkg::mc_y_width-1:0] my_y_i,
   input  wire                           host_req_v_i,
   input  mc_pkg::mc_req_pkt_s           host_req_i,
   output logic                          host_req_ready_o,
   output logic                          host_rsp_v_o,
   output mc_pkg::mc_rsp_pkt_s           host_rsp_o,
   output logic [credit_width_lp-1:0]    out_credits_o
);

   logic                             req_v;
   mc_pkg::mc_req_pkt_s              req;
   logic                             req_ready;
   logic                             rsp_v;
   mc_pkg::mc_rsp_pkt_s              rsp;
   logic                             rsp_ready;
   logic                             out_v;
   mc_pkg::mc_req_pkt_s              out;
   logic                             out_ready;
   logic                             in_rsp_v;
   mc_pkg::mc_rsp_pkt_s              in_rsp;

   logic                             dmem_rd_en;
   logic                             dmem_wr_en;
   logic [dmem_addr_width_lp-1:0]    dmem_addr;
   logic [mc_pkg::mc_mask_width-1:0] dmem_wr_mask;
   logic [mc_pkg::mc_data_width-1:0] dmem_wr_data;
   logic [mc_pkg::mc_data_width-1:0] dmem_rd_data;
   logic                             dmem_ready;

   mc_endpoint #(
      .req_fifo_els_p   (req_fifo_els_p),
      .max_out_credits_p(max_out_credits_p)
   ) endpoint (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .link_i          (link_i),
      .link_o          (link_o),
      .core_req_v_o    (req_v),
      .core_req_o      (req),
      .core_req_ready_i(req_ready),
      .core_rsp_v_i    (rsp_v),
      .core_rsp_i      (rsp),
      .core_rsp_ready_o(rsp_ready),
      .core_out_v_i    (out_v),
      .core_out_i      (out),
      .core_out_ready_o(out_ready),
      .in_rsp_v_o      (in_rsp_v),
      .in_rsp_o        (in_rsp),
      .out_credits_o   (out_credits_o)
   );

   mc_tile_core #(
      .dmem_words_p(dmem_words_p)
   ) core (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .my_x_i          (my_x_i),
      .my_y_i          (my_y_i),
      .req_v_i         (req_v),
      .req_i           (req),
      .req_ready_o     (req_ready),
      .rsp_v_o         (rsp_v),
      .rsp_o           (rsp),
      .rsp_ready_i     (rsp_ready),
      .dmem_rd_en_o    (dmem_rd_en),
      .dmem_wr_en_o    (dmem_wr_en),
      .dmem_addr_o     (dmem_addr),
      .dmem_wr_mask_o  (dmem_wr_mask),
      .dmem_wr_data_o  (dmem_wr_data),
      .dmem_rd_data_i  (dmem_rd_data),
      .dmem_ready_i    (dmem_ready),
      .host_req_v_i    (host_req_v_i),
      .host_req_i      (host_req_i),
      .host_req_ready_o(host_req_ready_o),
      .out_v_o         (out_v),
      .out_o           (out),
      .out_ready_i     (out_ready),
      .in_rsp_v_i      (in_rsp_v),
      .in_rsp_i        (in_rsp),
      .host_rsp_v_o    (host_rsp_v_o),
      .host_rsp_o      (host_rsp_o)
   );

   mc_dmem #(
      .dmem_words_p(dmem_words_p)
   ) dmem (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .rd_en_i    (dmem_rd_en),
      .wr_en_i    (dmem_wr_en),
      .addr_i     (dmem_addr),
      .wr_mask_i  (dmem_wr_mask),
      .wr_data_i  (dmem_wr_data),
      .rd_data_o  (dmem_rd_data),
      .init_done_o(dmem_ready)
   );

endmodule

`default_nettype wire

/* verilog/mc_tile_core.sv */
// ****************************************
// request server for remote loads/stores
// plus host request and response path
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module mc_tile_core #(
   parameter int dmem_words_p = 256,
   localparam int dmem_addr_width_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1
) (
   input  wire                                clk_i,
   input  wire                                rst_n_i,
   input  wire  [mc_pkg::mc_x_width-1:0]      my_x_i,
   input  wire  [mc_pkg::mc_y_width-1:0]      my_y_i,
   // remote requests and their responses
   input  wire                                req_v_i,
   input  mc_pkg::mc_req_pkt_s                req_i,
   output logic                               req_ready_o,
   output logic                               rsp_v_o,
   output mc_pkg::mc_rsp_pkt_s                rsp_o,
   input  wire                                rsp_ready_i,
   // data memory
   output logic                               dmem_rd_en_o,
   output logic                               dmem_wr_en_o,
   output logic [dmem_addr_width_lp-1:0]      dmem_addr_o,
   output logic [mc_pkg::mc_mask_width-1:0]   dmem_wr_mask_o,
   output logic [mc_pkg::mc_data_width-1:0]   dmem_wr_data_o,
   input  wire  [mc_pkg::mc_data_width-1:0]   dmem_rd_data_i,
   input  wire                                dmem_ready_i,
   // host port
   input  wire                                host_req_v_i,
   input  mc_pkg::mc_req_pkt_s                host_req_i,
   output logic                               host_req_ready_o,
   output logic                               out_v_o,
   output mc_pkg::mc_req_pkt_s                out_o,
   input  wire                                out_ready_i,
   input  wire                                in_rsp_v_i,
   input  mc_pkg::mc_rsp_pkt_s                in_rsp_i,
   output logic                               host_rsp_v_o,
   output mc_pkg::mc_rsp_pkt_s                host_rsp_o
);

   logic                stage_v_r;
   logic                rsp_v_r;
   mc_pkg::mc_rsp_pkt_s hdr_r;
   logic                pop;
   logic                is_load;

   // one request in flight: no pop while staging or holding a response
   assign req_ready_o = dmem_ready_i & ~stage_v_r & ~rsp_v_r;
   assign pop         = req_v_i & req_ready_o;
   assign is_load     = (req_i.op == mc_pkg::op_load);

   assign dmem_rd_en_o   = pop & is_load;
   assign dmem_wr_en_o   = pop & ~is_load;
   assign dmem_addr_o    = dmem_addr_width_lp'(req_i.addr % dmem_words_p);
   assign dmem_wr_mask_o = req_i.mask;
   assign dmem_wr_data_o = req_i.payload.store_data;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stage_v_r <= 1'b0;
         rsp_v_r   <= 1'b0;
      end else begin
         stage_v_r <= pop;
         if (stage_v_r) begin
            rsp_v_r <= 1'b1;
         end else if (rsp_v_r && rsp_ready_i) begin
            rsp_v_r <= 1'b0;
         end
      end
   end

   // header is captured at the pop, data joins from dmem a cycle later
   always_ff @(posedge clk_i) begin
      if (pop) begin
         hdr_r.rsp_type <= is_load ? mc_pkg::rsp_load_data : mc_pkg::rsp_store_ack;
         hdr_r.reg_id   <= is_load ? req_i.payload.load_info.reg_id : '0;
         hdr_r.data     <= '0;
         hdr_r.dst_x    <= req_i.src_x;
         hdr_r.dst_y    <= req_i.src_y;
      end
   end

   // dmem read data holds until the next read, which cannot start while pending
   always_comb begin
      rsp_o = hdr_r;
      if (hdr_r.rsp_type == mc_pkg::rsp_load_data) begin
         rsp_o.data = dmem_rd_data_i;
      end
   end
   assign rsp_v_o = rsp_v_r;

   // host requests leave with this tile as source
   always_comb begin
      out_o       = host_req_i;
      out_o.src_x = my_x_i;
      out_o.src_y = my_y_i;
   end
   assign out_v_o          = host_req_v_i;
   assign host_req_ready_o = out_ready_i;

   assign host_rsp_v_o = in_rsp_v_i;
   assign host_rsp_o   = in_rsp_i;

endmodule

`default_nettype wire

/* verilog/mc_dmem.sv */
// ****************************************
// local data memory, byte-masked writes,
// registered reads, clear after reset
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module mc_dmem #(
   parameter int dmem_words_p = 256,
   localparam int addr_width_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1
) (
   input  wire                                   clk_i,
   input  wire                                   rst_n_i,
   input  wire                                   rd_en_i,
   input  wire                                   wr_en_i,
   input  wire  [addr_width_lp-1:0]              addr_i,
   input  wire  [mc_pkg::mc_mask_width-1:0]      wr_mask_i,
   input  wire  [mc_pkg::mc_data_width-1:0]      wr_data_i,
   output logic [mc_pkg::mc_data_width-1:0]      rd_data_o,
   output logic                                  init_done_o
);

   logic [mc_pkg::mc_data_width-1:0] mem_r [dmem_words_p];
   logic [mc_pkg::mc_data_width-1:0] rd_data_r;
   logic [addr_width_lp-1:0]         clr_addr_r;
   logic                             init_done_r;

   assign rd_data_o   = rd_data_r;
   assign init_done_o = init_done_r;

   // walk every word once after reset
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         clr_addr_r  <= '0;
         init_done_r <= 1'b0;
      end else if (!init_done_r) begin
         if (clr_addr_r == addr_width_lp'(dmem_words_p - 1)) begin
            init_done_r <= 1'b1;
         end else begin
            clr_addr_r <= clr_addr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!init_done_r) begin
         mem_r[clr_addr_r] <= '0;
      end else if (wr_en_i) begin
         for (int b = 0; b < mc_pkg::mc_mask_width; b++) begin
            if (wr_mask_i[b]) begin
               mem_r[addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
         end
      end
      if (rd_en_i) begin
         rd_data_r <= mem_r[addr_i];
      end
   end

endmodule

`default_nettype wire

/* verilog/mc_endpoint.sv */
// ****************************************
// link endpoint: request buffer, response
// pass-through and out-credit counter
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module mc_endpoint #(
   parameter int req_fifo_els_p    = 2,
   parameter int max_out_credits_p = 4,
   localparam int credit_width_lp  = $clog2(max_out_credits_p + 1)
) (
   input  wire                        clk_i,
   input  wire                        rst_n_i,
   input  mc_pkg::mc_link_in_s        link_i,
   output mc_pkg::mc_link_out_s       link_o,
   // buffered requests toward the core
   output logic                       core_req_v_o,
   output mc_pkg::mc_req_pkt_s        core_req_o,
   input  wire                        core_req_ready_i,
   // core responses toward the link
   input  wire                        core_rsp_v_i,
   input  mc_pkg::mc_rsp_pkt_s        core_rsp_i,
   output logic                       core_rsp_ready_o,
   // outgoing requests from the core
   input  wire                        core_out_v_i,
   input  mc_pkg::mc_req_pkt_s        core_out_i,
   output logic                       core_out_ready_o,
   // incoming responses as a strobe
   output logic                       in_rsp_v_o,
   output mc_pkg::mc_rsp_pkt_s        in_rsp_o,
   output logic [credit_width_lp-1:0] out_credits_o
);

   logic                       fifo_ready;
   logic                       link_open_r;
   logic                       rsp_ready_r;
   logic [credit_width_lp-1:0] credits_r;
   logic                       credit_avail;
   logic                       out_sent;
   logic                       rsp_recv;
   logic                       in_rsp_v_r;
   mc_pkg::mc_rsp_pkt_s        in_rsp_r;

   mc_fifo #(
      .els_p(req_fifo_els_p)
   ) req_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .v_i         (link_i.req_v),
      .data_i      (link_i.req),
      .yumi_ready_i(core_req_ready_i),
      .ready_o     (fifo_ready),
      .v_o         (core_req_v_o),
      .data_o      (core_req_o)
   );

   assign credit_avail = (credits_r != '0);
   assign out_sent     = core_out_v_i & credit_avail & link_i.req_ready;
   assign rsp_recv     = link_i.rsp_v & rsp_ready_r;

   always_comb begin
      link_o           = '0;
      // requests are only taken once the core has come up after memory clear
      link_o.req_ready = fifo_ready & link_open_r;
      link_o.rsp_v     = core_rsp_v_i;
      link_o.rsp       = core_rsp_i;
      link_o.req_v     = core_out_v_i & credit_avail;
      link_o.req       = core_out_i;
      link_o.rsp_ready = rsp_ready_r;
   end

   assign core_rsp_ready_o = link_i.rsp_ready;
   assign core_out_ready_o = link_i.req_ready & credit_avail;
   assign in_rsp_v_o       = in_rsp_v_r;
   assign in_rsp_o         = in_rsp_r;
   assign out_credits_o    = credits_r;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         link_open_r <= 1'b0;
         rsp_ready_r <= 1'b0;
         in_rsp_v_r  <= 1'b0;
         credits_r   <= credit_width_lp'(max_out_credits_p);
      end else begin
         if (core_req_ready_i) begin
            link_open_r <= 1'b1;
         end
         // incoming responses are always drained
         rsp_ready_r <= 1'b1;
         in_rsp_v_r  <= rsp_recv;
         credits_r   <= credits_r + credit_width_lp'(rsp_recv)
                        - credit_width_lp'(out_sent);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rsp_recv) begin
         in_rsp_r <= link_i.rsp;
      end
   end

endmodule

`default_nettype wire

/* verilog/mc_fifo.sv */
// ****************************************
// circular valid/ready FIFO for
// request packets
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module mc_fifo #(
   parameter int els_p = 2,
   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1,
   localparam int cnt_width_lp = $clog2(els_p + 1)
) (
   input  wire                 clk_i,
   input  wire                 rst_n_i,
   input  wire                 v_i,
   input  mc_pkg::mc_req_pkt_s data_i,
   input  wire                 yumi_ready_i,
   output logic                ready_o,
   output logic                v_o,
   output mc_pkg::mc_req_pkt_s data_o
);

   mc_pkg::mc_req_pkt_s     mem_r [els_p];
   logic [ptr_width_lp-1:0] rd_ptr_r;
   logic [ptr_width_lp-1:0] wr_ptr_r;
   logic [cnt_width_lp-1:0] cnt_r;
   logic                    push;
   logic                    pop;

   // wrap by compare so depths other than powers of two work
   function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] p);
      if (p == ptr_width_lp'(els_p - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   assign ready_o = (cnt_r != cnt_width_lp'(els_p));
   assign v_o     = (cnt_r != '0);
   assign data_o  = mem_r[rd_ptr_r];
   assign push    = v_i & ready_o;
   assign pop     = v_o & yumi_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr_r <= '0;
         wr_ptr_r <= '0;
         cnt_r    <= '0;
      end else begin
         if (push) begin
            wr_ptr_r <= next_ptr(wr_ptr_r);
         end
         if (pop) begin
            rd_ptr_r <= next_ptr(rd_ptr_r);
         end
         cnt_r <= cnt_r + cnt_width_lp'(push) - cnt_width_lp'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

endmodule

`default_nettype wire

/* verilog/mc_pkg.sv */
// ****************************************
// shared packet types for the tile socket
// opcodes, payload union, link structs
// ****************************************
`default_nettype none

package mc_pkg;

   localparam int mc_x_width      = 4;
   localparam int mc_y_width      = 4;
   localparam int mc_addr_width   = 16;
   localparam int mc_reg_id_width = 5;
   localparam int mc_data_width   = 32;
   localparam int mc_mask_width   = mc_data_width / 8;

   typedef enum logic {
      op_load  = 1'b0,
      op_store = 1'b1
   } mc_op_e;

   typedef enum logic {
      rsp_load_data = 1'b0,
      rsp_store_ack = 1'b1
   } mc_rsp_type_e;

   // loads carry the destination register tag in the low bits
   typedef struct packed {
      logic [mc_data_width-mc_reg_id_width-1:0] pad;
      logic [mc_reg_id_width-1:0]               reg_id;
   } mc_load_info_s;

   // decoded by opcode: raw word for stores, load info for loads
   typedef union packed {
      logic [mc_data_width-1:0] store_data;
      mc_load_info_s            load_info;
   } mc_payload_u;

   typedef struct packed {
      mc_op_e                   op;
      logic [mc_mask_width-1:0] mask;
      logic [mc_addr_width-1:0] addr;
      mc_payload_u              payload;
      logic [mc_x_width-1:0]    src_x;
      logic [mc_y_width-1:0]    src_y;
      logic [mc_x_width-1:0]    dst_x;
      logic [mc_y_width-1:0]    dst_y;
   } mc_req_pkt_s;

   typedef struct packed {
      mc_rsp_type_e               rsp_type;
      logic [mc_reg_id_width-1:0] reg_id;
      logic [mc_data_width-1:0]   data;
      logic [mc_x_width-1:0]      dst_x;
      logic [mc_y_width-1:0]      dst_y;
   } mc_rsp_pkt_s;

   // network side into the tile; the ready bits belong to tile outputs
   typedef struct packed {
      logic        req_v;
      mc_req_pkt_s req;
      logic        rsp_v;
      mc_rsp_pkt_s rsp;
      logic        req_ready;
      logic        rsp_ready;
   } mc_link_in_s;

   typedef struct packed {
      logic        req_v;
      mc_req_pkt_s req;
      logic        rsp_v;
      mc_rsp_pkt_s rsp;
      logic        req_ready;
      logic        rsp_ready;
   } mc_link_out_s;

endpackage

`default_nettype wire
